// ==== logic/mc_cfg_pkg.sv ====
package mc_cfg_pkg;

	// ==================================================
	// subsystem sizing
	// ==================================================

	localparam int N_CORES    = 4;
	localparam int CORE_IDX_W = 2; // enough for N_CORES-1

	localparam int DATA_W    = 32;
	localparam int BURST_LEN = 4; // words per sum

	// wide sum, no overflow over one burst
	localparam int SUM_W = DATA_W + $clog2(BURST_LEN);

	// phase runs 0..BURST_LEN, last value is the result cycle
	localparam int PHASE_W = $clog2(BURST_LEN + 1);

	// ==================================================
	// reset release timing
	// ==================================================

	localparam int RELEASE_GAP = 8; // cycles between core releases
	localparam int GAP_CNT_W   = 4;

endpackage

// ==== logic/mc_types_pkg.sv ====
package mc_types_pkg;

	import mc_cfg_pkg::*;

	// input request from a core
	typedef enum logic [1:0] {
		REQ_IDLE = 2'd0,
		REQ_WORD = 2'd1 // sample io_in this cycle
	} req_e;

	// kind of a core result
	typedef enum logic [1:0] {
		OUT_NONE   = 2'd0,
		OUT_RESULT = 2'd1, // sum in range
		OUT_SAT    = 2'd2  // sum clipped
	} out_kind_e;

	// one core result, 34 bits
	typedef struct packed {
		logic signed [DATA_W-1:0] data;
		out_kind_e                kind;
	} core_out_t;

	// selected result with its source core
	typedef struct packed {
		core_out_t             result;
		logic [CORE_IDX_W-1:0] idx;
	} sel_out_t;

endpackage

// ==== logic/reset_stagger.sv ====
`timescale 1ns/1ps

module reset_stagger import mc_cfg_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	output logic [N_CORES-1:0] core_rst_n
);

	logic [GAP_CNT_W-1:0]  gap_cnt;
	logic [CORE_IDX_W-1:0] rel_idx;
	logic                  done;
	logic                  release_now;

	// a release happens when the gap has run out
	assign release_now = !done && (gap_cnt == '0);

	// ==================================================
	// gap counter and release index
	// ==================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gap_cnt <= '0; // first release right away
			rel_idx <= '0;
			done    <= 1'b0;
		end else if (release_now) begin
			gap_cnt <= GAP_CNT_W'(RELEASE_GAP - 1);
			if (rel_idx == CORE_IDX_W'(N_CORES - 1)) begin
				done <= 1'b1; // counter stops here
			end else begin
				rel_idx <= rel_idx + 1'b1;
			end
		end else if (!done) begin
			gap_cnt <= gap_cnt - 1'b1;
		end
	end

	// ==================================================
	// per-core reset bits
	// ==================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			core_rst_n <= '0; // all cores held
		end else if (release_now) begin
			core_rst_n[rel_idx] <= 1'b1;
		end
	end

	// once released, a core stays out of reset until the next system reset
	a_release_monotonic: assert property (
		@(posedge clk) disable iff (!arst_n)
		(core_rst_n & $past(core_rst_n)) == $past(core_rst_n)
	);

	// successive releases are RELEASE_GAP cycles apart
	a_release_spacing: assert property (
		@(posedge clk) disable iff (!arst_n)
		(release_now && !(rel_idx == CORE_IDX_W'(N_CORES - 1)))
			|-> ##RELEASE_GAP release_now
	);

endmodule

// ==== logic/stream_core.sv ====
`timescale 1ns/1ps

module stream_core import mc_cfg_pkg::*, mc_types_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     core_rst_n,
	input  logic signed [DATA_W-1:0] io_in,
	output req_e                     req,
	output core_out_t                res
);

	localparam logic signed [DATA_W-1:0] DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
	localparam logic signed [DATA_W-1:0] DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

	logic [PHASE_W-1:0]       phase;
	logic                     res_cycle;
	logic signed [SUM_W-1:0]  acc;
	logic [SUM_W-DATA_W:0]    acc_top; // bits that must agree with the sign
	logic                     ovf;
	logic signed [DATA_W-1:0] sat_data;

	assign res_cycle = (phase == PHASE_W'(BURST_LEN));

	// sampling for BURST_LEN cycles, idle while in core reset
	assign req = (core_rst_n && !res_cycle) ? REQ_WORD : REQ_IDLE;

	// ==================================================
	// phase counter
	// ==================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= '0;
		end else if (!core_rst_n) begin
			phase <= '0;
		end else if (res_cycle) begin
			phase <= '0; // next burst
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// ==================================================
	// accumulator
	// ==================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (!core_rst_n || res_cycle) begin
			acc <= '0;
		end else if (req == REQ_WORD) begin
			acc <= acc + SUM_W'(io_in); // sign extended
		end
	end

	// ==================================================
	// saturation and result
	// ==================================================

	assign acc_top = acc[SUM_W-1:DATA_W-1];

	// out of range unless the top bits are all equal
	assign ovf = !((&acc_top) || !(|acc_top));

	always_comb begin
		if (!ovf) begin
			sat_data = acc[DATA_W-1:0];
		end else if (acc[SUM_W-1]) begin
			sat_data = DATA_MIN;
		end else begin
			sat_data = DATA_MAX;
		end
	end

	always_comb begin
		res.data = sat_data;
		if (!res_cycle) begin
			res.kind = OUT_NONE;
		end else if (ovf) begin
			res.kind = OUT_SAT;
		end else begin
			res.kind = OUT_RESULT;
		end
	end

	// a core never asks for input while presenting its result
	a_req_vs_result: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(req == REQ_WORD && res.kind != OUT_NONE)
	);

	a_phase_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		phase <= PHASE_W'(BURST_LEN)
	);

	// each result follows exactly BURST_LEN sampling cycles
	a_burst_before_result: assert property (
		@(posedge clk) disable iff (!arst_n || !core_rst_n)
		(res.kind != OUT_NONE) |-> $past(req == REQ_WORD, 1)
			&& $past(req == REQ_WORD, BURST_LEN)
	);

endmodule

// ==== logic/out_select.sv ====
`timescale 1ns/1ps

module out_select import mc_cfg_pkg::*, mc_types_pkg::*; #(
	parameter type payload_t = core_out_t // needs a kind field
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t cand [N_CORES],
	output sel_out_t sel,
	output logic     collision
);

	sel_out_t sel_d;
	logic     found;
	logic     multi;

	// ==================================================
	// fixed priority, lowest index wins
	// ==================================================

	always_comb begin
		sel_d = '0; // kind OUT_NONE
		found = 1'b0;
		multi = 1'b0;
		for (int i = 0; i < N_CORES; i++) begin
			if (cand[i].kind != OUT_NONE) begin
				if (found) begin
					multi = 1'b1; // loser dropped
				end else begin
					found        = 1'b1;
					sel_d.result = core_out_t'(cand[i]);
					sel_d.idx    = CORE_IDX_W'(i);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel       <= '0;
			collision <= 1'b0;
		end else begin
			sel       <= sel_d;
			collision <= multi;
		end
	end

	a_idx_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		(sel.result.kind != OUT_NONE) |-> (sel.idx <= CORE_IDX_W'(N_CORES - 1))
	);

endmodule

// ==== logic/multicore_top.sv ====
`timescale 1ns/1ps

module multicore_top import mc_cfg_pkg::*, mc_types_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic signed [DATA_W-1:0] io_in,
	output sel_out_t                 result,
	output logic                     collision,
	output logic [N_CORES-1:0]       core_req
);

	logic [N_CORES-1:0] core_rst_n;
	req_e               req_code [N_CORES];
	core_out_t          core_res [N_CORES];

	// ==================================================
	// staggered reset release
	// ==================================================

	reset_stagger u_stagger (
		.clk        (clk),
		.arst_n     (arst_n),
		.core_rst_n (core_rst_n)
	);

	// ==================================================
	// cores on the broadcast word
	// ==================================================

	for (genvar k = 0; k < N_CORES; k++) begin : g_core
		stream_core u_core (
			.clk        (clk),
			.arst_n     (arst_n),
			.core_rst_n (core_rst_n[k]),
			.io_in      (io_in),
			.req        (req_code[k]),
			.res        (core_res[k])
		);

		assign core_req[k] = (req_code[k] == REQ_WORD);
	end

	// ==================================================
	// result selection
	// ==================================================

	out_select #(
		.payload_t (core_out_t)
	) u_sel (
		.clk       (clk),
		.arst_n    (arst_n),
		.cand      (core_res),
		.sel       (result),
		.collision (collision)
	);

endmodule

// ==== tests/mc_checker.sv ====
`timescale 1ns/1ps

module mc_checker import mc_cfg_pkg::*, mc_types_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic signed [DATA_W-1:0] io_in,
	input  sel_out_t                 result,
	input  logic                     collision,
	input  logic [N_CORES-1:0]       core_req,
	output int                       err_cnt,
	output int                       cmp_cnt
);

	localparam int     PERIOD  = BURST_LEN + 1; // burst plus result cycle
	localparam longint SUM_MAX = (longint'(1) <<< (DATA_W - 1)) - 1;
	localparam longint SUM_MIN = -(longint'(1) <<< (DATA_W - 1));

	int       errors = 0;
	int       checked = 0;
	int       edge_cnt = 0; // rising edges since system reset release
	longint   sum_model [N_CORES];
	sel_out_t exp_sel = '0; // selector register model
	logic     exp_coll = 1'b0;

	assign err_cnt = errors;
	assign cmp_cnt = checked;

	function automatic core_out_t clip_sum(input longint s);
		core_out_t r;
		if (s > SUM_MAX) begin
			r.data = DATA_W'(SUM_MAX);
			r.kind = OUT_SAT;
		end else if (s < SUM_MIN) begin
			r.data = DATA_W'(SUM_MIN);
			r.kind = OUT_SAT;
		end else begin
			r.data = DATA_W'(s);
			r.kind = OUT_RESULT;
		end
		return r;
	endfunction

	task automatic report_mismatch(input string test, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		$display("mismatch %s at %0t: expected %0h, actual %0h", test, $time, exp_v, act_v);
		errors++;
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			edge_cnt <= 0;
		end else begin
			edge_cnt <= edge_cnt + 1;
		end
	end

	// ==================================================
	// cycle model, sampled mid-cycle
	// ==================================================

	always @(negedge clk) begin : sample
		logic [N_CORES-1:0] want_req;
		sel_out_t           next_sel;
		int                 hits;
		int                 start;
		int                 ph;

		want_req = '0;
		next_sel = '0;
		hits     = 0;
		if (!arst_n) begin
			if (result.result.kind !== OUT_NONE)
				report_mismatch("reset_kind", OUT_NONE, result.result.kind);
			if (collision !== 1'b0)
				report_mismatch("reset_collision", 1'b0, collision);
			if (core_req !== '0)
				report_mismatch("reset_core_req", '0, core_req);
			for (int k = 0; k < N_CORES; k++) begin
				sum_model[k] = 0;
			end
			exp_sel  = '0;
			exp_coll = 1'b0;
		end else begin
			for (int k = 0; k < N_CORES; k++) begin
				start = k * RELEASE_GAP + 1; // first request cycle of core k
				if (edge_cnt >= start) begin
					ph = (edge_cnt - start) % PERIOD;
					if (ph < BURST_LEN) begin
						want_req[k]  = 1'b1;
						sum_model[k] = sum_model[k] + longint'(io_in);
					end else begin
						hits++;
						if (hits == 1) begin // lowest index wins
							next_sel.result = clip_sum(sum_model[k]);
							next_sel.idx    = CORE_IDX_W'(k);
						end
						sum_model[k] = 0;
					end
				end
			end

			if (core_req !== want_req)
				report_mismatch("core_req", want_req, core_req);

			if (exp_sel.result.kind == OUT_NONE) begin
				if (result.result.kind !== OUT_NONE)
					report_mismatch("result_kind", OUT_NONE, result.result.kind);
			end else begin
				checked++;
				if (result.result.kind !== exp_sel.result.kind)
					report_mismatch("result_kind", exp_sel.result.kind, result.result.kind);
				if (result.result.data !== exp_sel.result.data)
					report_mismatch("burst_sum", exp_sel.result.data, result.result.data);
				if (result.idx !== exp_sel.idx)
					report_mismatch("result_idx", exp_sel.idx, result.idx);
			end

			if (collision !== exp_coll)
				report_mismatch("collision", exp_coll, collision);

			exp_sel  = next_sel; // shows up one cycle later
			exp_coll = (hits > 1);
		end
	end

endmodule

// ==== tests/tb_multicore.sv ====
`timescale 1ns/1ps

module tb_multicore import mc_cfg_pkg::*, mc_types_pkg::*; ();

	localparam int CLK_PERIOD  = 10;
	localparam int DRIVE_DELAY = 2;
	localparam int RAND_SEED   = 21819;
	localparam int RAND_SPAN   = 1 << 20; // random words stay far from clipping
	localparam int MAX_CYCLES  = 400;
	localparam int EDGE_LIMIT  = 4;       // clock changes allowed per wait
	localparam int N_ROWS      = 7;

	typedef enum logic [1:0] {
		ROW_FIXED,
		ROW_RANDOM,
		ROW_RESET
	} row_mode_e;

	typedef struct packed {
		row_mode_e                mode;
		logic signed [DATA_W-1:0] word;
		int                       cycles;
		int                       exp_results;
		int                       exp_sat;
	} row_t;

	logic                     clk;
	logic                     arst_n;
	logic signed [DATA_W-1:0] io_in;
	sel_out_t                 result;
	logic                     collision;
	logic [N_CORES-1:0]       core_req;

	row_t        rows [N_ROWS];
	string       row_name [N_ROWS];
	int          tb_errors;
	int          chk_errors;
	int          chk_results;
	logic        timed_out;

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	multicore_top dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.io_in     (io_in),
		.result    (result),
		.collision (collision),
		.core_req  (core_req)
	);

	mc_checker chk0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.io_in     (io_in),
		.result    (result),
		.collision (collision),
		.core_req  (core_req),
		.err_cnt   (chk_errors),
		.cmp_cnt   (chk_results)
	);

	// ==================================================
	// stimulus table
	// ==================================================

	task automatic set_row(input int idx, input string name, input row_mode_e mode,
			input logic signed [DATA_W-1:0] word, input int cycles,
			input int exp_results, input int exp_sat);
		rows[idx].mode        = mode;
		rows[idx].word        = word;
		rows[idx].cycles      = cycles;
		rows[idx].exp_results = exp_results;
		rows[idx].exp_sat     = exp_sat;
		row_name[idx]         = name;
	endtask

	// counts are top results seen while the row is applied
	task automatic fill_table;
		set_row(0, "release",   ROW_RANDOM, '0,               40, 19,  0);
		set_row(1, "sat_pos",   ROW_FIXED,  32'sh7fff_ffff,   20, 16, 14);
		set_row(2, "sat_neg",   ROW_FIXED,  32'sh8000_0000,   20, 16, 16);
		set_row(3, "mixed",     ROW_RANDOM, '0,               20, 16,  3);
		set_row(4, "mid_reset", ROW_RESET,  '0,                3,  0,  0);
		set_row(5, "restart",   ROW_RANDOM, '0,               40, 19,  0);
		set_row(6, "steady",    ROW_RANDOM, '0,               20, 16,  0);
	endtask

	function automatic logic signed [DATA_W-1:0] next_word(input row_t row);
		case (row.mode)
			ROW_FIXED:  return row.word;
			ROW_RANDOM: return DATA_W'(1 + ($urandom % RAND_SPAN)); // never zero
			default:    return '0;
		endcase
	endfunction

	task automatic wait_level(input logic level);
		int guard;
		guard = 0;
		do begin
			@(clk);
			guard++;
		end while (clk !== level && guard < EDGE_LIMIT);
		if (clk !== level) begin
			$display("timeout: clock did not reach level %b", level);
			timed_out = 1'b1;
			disable run_rows;
		end
	endtask

	task automatic check_count(input string test, input string what, input int exp_v,
			input int act_v);
		if (act_v != exp_v) begin
			$display("mismatch %s %s: expected %0d, actual %0d", test, what, exp_v, act_v);
			tb_errors++;
		end
	endtask

	task automatic report_and_finish;
		if (chk_results == 0) begin
			$display("checker compared no results");
			tb_errors++;
		end
		$display("errors: %0d table, %0d checker, %0d timeout", tb_errors, chk_errors,
			timed_out);
		if (tb_errors == 0 && chk_errors == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	// ==================================================
	// main sequence
	// ==================================================

	initial begin
		arst_n    = 1'b0;
		io_in     = '0;
		tb_errors = 0;
		timed_out = 1'b0;
		void'($urandom(RAND_SEED)); // seeds the generator
		fill_table();
		begin : run_rows
			int res_seen;
			int sat_seen;
			for (int i = 0; i < 3; i++) begin
				wait_level(1'b1); // reset held over three edges
			end
			#(DRIVE_DELAY);
			for (int r = 0; r < N_ROWS; r++) begin
				res_seen = 0;
				sat_seen = 0;
				for (int c = 0; c < rows[r].cycles; c++) begin
					arst_n = (rows[r].mode != ROW_RESET);
					io_in  = next_word(rows[r]);
					wait_level(1'b0);
					if (result.result.kind != OUT_NONE)
						res_seen++;
					if (result.result.kind == OUT_SAT)
						sat_seen++;
					wait_level(1'b1);
					#(DRIVE_DELAY);
				end
				check_count(row_name[r], "results", rows[r].exp_results, res_seen);
				check_count(row_name[r], "saturated", rows[r].exp_sat, sat_seen);
			end
		end
		report_and_finish();
	end

	initial begin : watchdog
		for (int i = 0; i < MAX_CYCLES; i++) begin
			#(CLK_PERIOD);
		end
		$display("timeout: stimulus not done after %0d cycles", MAX_CYCLES);
		timed_out = 1'b1;
		disable run_rows;
	end

endmodule

// ==== filelist.f ====
logic/mc_cfg_pkg.sv
logic/mc_types_pkg.sv
logic/reset_stagger.sv
logic/stream_core.sv
logic/out_select.sv
logic/multicore_top.sv
tests/mc_checker.sv
tests/tb_multicore.sv

// ==== Bender.yml ====
package:
  name: multicore_stream

sources:
  - logic/mc_cfg_pkg.sv
  - logic/mc_types_pkg.sv
  - logic/reset_stagger.sv
  - logic/stream_core.sv
  - logic/out_select.sv
  - logic/multicore_top.sv
  - target: test
    files:
      - tests/mc_checker.sv
      - tests/tb_multicore.sv
